// ==== build.f ====
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/cpu_sequencer.sv
hw/cpu_pc_counter.sv
hw/cpu_alu.sv
hw/cpu_regfile.sv
hw/m6502_core.sv
tb/tb_clock.sv
tb/cpu_sva.sv
tb/tb_m6502_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_m6502_core
FILELIST  ?= build.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== tb/tb_m6502_core.sv ====
// Directed testbench for m6502_core. A 64 KiB memory model answers the bus,
// each test assembles a small program and checks the bus writes it makes.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module tb_m6502_core;

   localparam int LIMIT = 5000;   // Cycles per wait

   logic               clk;
   logic               por_n;
   logic               rst_req_n;
   logic               reset_n;
   cpu_bus_pkg::addr_t addr;
   logic               rd_req;
   logic               wr_en;
   cpu_bus_pkg::data_t wr_data;
   cpu_bus_pkg::data_t rd_data;
   logic               ready;
   logic               random_ready;
   integer             seed;
   int                 wr_idx;
   cpu_bus_pkg::addr_t asm_pc;
   cpu_bus_pkg::data_t mem [0:65535];
   cpu_bus_pkg::addr_t rd_addr_q[$];
   cpu_bus_pkg::addr_t wr_addr_q[$];
   cpu_bus_pkg::data_t wr_data_q[$];
   cpu_bus_pkg::data_t alu_a [8];
   cpu_bus_pkg::data_t alu_b [8];
   int                 alu_sel [8];
   logic               alu_cin [8];

   assign reset_n = por_n & rst_req_n;

   tb_clock clk0 (.clk_o(clk), .reset_n_o(por_n));

   m6502_core dut0 (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr_o    (addr),
      .rd_req_o  (rd_req),
      .wr_en_o   (wr_en),
      .wr_data_o (wr_data),
      .rd_data_i (rd_data),
      .ready_i   (ready)
   );

   // Memory model answers one cycle after the completing edge
   always @(posedge clk)
   begin
      ready <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
      if (rd_req && ready)
      begin
         rd_data <= mem[addr];
         rd_addr_q.push_back(addr);
      end
      if (wr_en && ready)
      begin
         mem[addr] <= wr_data;
         wr_addr_q.push_back(addr);
         wr_data_q.push_back(wr_data);
      end
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("** FAIL **");
      $fatal(1, "test stopped");
   endtask

   // Stop at the first failed bus assertion
   always @(negedge clk)
   begin
      if (dut0.sva0.fail_count != 0)
         report_failure("bus protocol assertion failed");
   end

   task automatic check_addr(input string name, input cpu_bus_pkg::addr_t got,
                             input cpu_bus_pkg::addr_t exp);
      if (got !== exp)
         report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_data(input string name, input cpu_bus_pkg::data_t got,
                             input cpu_bus_pkg::data_t exp);
      if (got !== exp)
         report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
   endtask

   function automatic cpu_bus_pkg::data_t fill_byte(input cpu_bus_pkg::addr_t a);
      return a[15:8] ^ a[7:0] ^ 8'h5A;
   endfunction

   task automatic emit(input cpu_bus_pkg::data_t b);
      mem[asm_pc] = b;
      asm_pc      = asm_pc + 1'b1;
   endtask

   task automatic emit_imm(input cpu_bus_pkg::data_t opc, input cpu_bus_pkg::data_t v);
      emit(opc);
      emit(v);
   endtask

   task automatic emit_abs(input cpu_bus_pkg::data_t opc, input cpu_bus_pkg::addr_t a);
      emit(opc);
      emit(a[7:0]);
      emit(a[15:8]);
   endtask

   // Holds reset, clears memory and logs, sets the vector to origin
   task automatic begin_program(input cpu_bus_pkg::addr_t origin);
      int i;
      @(posedge clk);
      rst_req_n <= 1'b0;
      @(negedge clk);
      rd_addr_q.delete();
      wr_addr_q.delete();
      wr_data_q.delete();
      wr_idx = 0;
      for (i = 0; i < 65536; i++)
         mem[i] = fill_byte(i[15:0]);
      mem[`RST_VECTOR]        = origin[7:0];
      mem[`RST_VECTOR + 1'b1] = origin[15:8];
      asm_pc = origin;
   endtask

   task automatic run_program();
      @(negedge clk);
      if (rd_req || wr_en)
         report_failure("bus strobe high while reset held");
      @(posedge clk);
      rst_req_n <= 1'b1;
   endtask

   task automatic wait_writes(input int n);
      int t;
      t = 0;
      while (wr_addr_q.size() < n)
      begin
         @(negedge clk);
         t++;
         if (t > LIMIT)
            report_failure($sformatf("timeout waiting for bus write number %0d", n));
      end
   endtask

   task automatic wait_reads(input int n);
      int t;
      t = 0;
      while (rd_addr_q.size() < n)
      begin
         @(negedge clk);
         t++;
         if (t > LIMIT)
            report_failure($sformatf("timeout waiting for bus read number %0d", n));
      end
   endtask

   task automatic expect_store(input cpu_bus_pkg::addr_t a, input cpu_bus_pkg::data_t d);
      wait_writes(wr_idx + 1);
      check_addr("addr_o", wr_addr_q[wr_idx], a);
      check_data("wr_data_o", wr_data_q[wr_idx], d);
      wr_idx++;
   endtask

   function automatic cpu_bus_pkg::data_t alu_expect(input int sel, input cpu_bus_pkg::data_t a,
                                                     input cpu_bus_pkg::data_t b, input logic c);
      case (sel)
         0:       return a + b + c;
         1:       return a & b;
         2:       return a | b;
         default: return a ^ b;
      endcase
   endfunction

   task automatic reset_vector_test();
      begin_program(16'h0456);
      emit_abs(`OPC_JMP_ABS, 16'h0456);
      run_program();
      wait_reads(3);
      check_addr("addr_o", rd_addr_q[0], 16'hFFFC);
      check_addr("addr_o", rd_addr_q[1], 16'hFFFD);
      check_addr("addr_o", rd_addr_q[2], 16'h0456);
   endtask

   task automatic load_store_test();
      cpu_bus_pkg::data_t r1;
      cpu_bus_pkg::data_t r2;
      cpu_bus_pkg::data_t r3;
      cpu_bus_pkg::data_t r4;
      cpu_bus_pkg::data_t r5;
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      r4 = $random(seed);
      r5 = $random(seed);
      begin_program(16'h0200);
      mem[16'h2000] = r5;
      emit_imm(`OPC_LDA_IMM, r1);
      emit_abs(`OPC_STA_ABS, 16'h3000);
      emit_imm(`OPC_LDX_IMM, r2);
      emit(`OPC_TXA);
      emit_abs(`OPC_STA_ABS, 16'h3001);
      emit_imm(`OPC_LDY_IMM, r3);      // A keeps r2
      emit_abs(`OPC_STA_ABS, 16'h3002);
      emit_imm(`OPC_LDA_IMM, r4);
      emit(`OPC_TAX);
      emit_imm(`OPC_LDA_IMM, 8'h00);
      emit(`OPC_TXA);
      emit_abs(`OPC_STA_ABS, 16'h3003);
      emit_abs(`OPC_LDA_ABS, 16'h2000);
      emit_abs(`OPC_STA_ABS, 16'h3004);
      emit_abs(`OPC_LDA_ABS, 16'h2345);  // Untouched fill byte
      emit_abs(`OPC_STA_ABS, 16'h3005);
      emit_abs(`OPC_JMP_ABS, asm_pc);
      run_program();
      expect_store(16'h3000, r1);
      expect_store(16'h3001, r2);
      expect_store(16'h3002, r2);
      expect_store(16'h3003, r4);
      expect_store(16'h3004, r5);
      expect_store(16'h3005, fill_byte(16'h2345));
   endtask

   task automatic run_alu_program();
      int i;
      cpu_bus_pkg::data_t opc [4];
      opc[0] = `OPC_ADC_IMM;
      opc[1] = `OPC_AND_IMM;
      opc[2] = `OPC_ORA_IMM;
      opc[3] = `OPC_EOR_IMM;
      begin_program(16'h0300);
      for (i = 0; i < 8; i++)
      begin
         emit_imm(`OPC_LDA_IMM, alu_a[i]);
         emit(alu_cin[i] ? `OPC_SEC : `OPC_CLC);
         emit_imm(opc[alu_sel[i]], alu_b[i]);
         emit_abs(`OPC_STA_ABS, 16'h3000 + i);
      end
      emit_abs(`OPC_JMP_ABS, asm_pc);
      run_program();
      for (i = 0; i < 8; i++)
         expect_store(16'h3000 + i, alu_expect(alu_sel[i], alu_a[i], alu_b[i], alu_cin[i]));
   endtask

   task automatic logic_arith_test();
      int i;
      for (i = 0; i < 8; i++)
      begin
         alu_a[i]   = $random(seed);
         alu_b[i]   = $random(seed);
         alu_sel[i] = i % 4;
         alu_cin[i] = $random(seed);
      end
      run_alu_program();
   endtask

   task automatic branch_test();
      int k;
      cpu_bus_pkg::data_t a [8];
      cpu_bus_pkg::data_t b;
      cpu_bus_pkg::data_t opc;
      logic taken [8];
      cpu_bus_pkg::data_t bops [4];
      bops[0] = `OPC_BEQ;
      bops[1] = `OPC_BNE;
      bops[2] = `OPC_BCC;
      bops[3] = `OPC_BCS;
      begin_program(16'h0500);
      for (k = 0; k < 8; k++)
      begin
         a[k] = $random(seed);
         // Each branch sees one equal and one random compare
         b    = ((k % 2) != (k / 4)) ? a[k] : $random(seed);
         opc  = bops[k % 4];
         case (k % 4)
            0:       taken[k] = (a[k] == b);
            1:       taken[k] = (a[k] != b);
            2:       taken[k] = (a[k] < b);
            default: taken[k] = (a[k] >= b);
         endcase
         if (k < 4)
         begin
            emit_imm(`OPC_LDA_IMM, a[k]);
            emit_imm(`OPC_CMP_IMM, b);
            emit_imm(opc, 8'h06);
            emit_abs(`OPC_STA_ABS, 16'h3100 + 2 * k);
            emit_abs(`OPC_JMP_ABS, asm_pc + 6);
            emit_abs(`OPC_STA_ABS, 16'h3101 + 2 * k);
         end
         else
         begin
            // Taken path sits before the branch
            emit_abs(`OPC_JMP_ABS, asm_pc + 9);
            emit_abs(`OPC_STA_ABS, 16'h3101 + 2 * k);
            emit_abs(`OPC_JMP_ABS, asm_pc + 12);
            emit_imm(`OPC_LDA_IMM, a[k]);
            emit_imm(`OPC_CMP_IMM, b);
            emit_imm(opc, 8'hF4);
            emit_abs(`OPC_STA_ABS, 16'h3100 + 2 * k);
         end
      end
      emit_abs(`OPC_JMP_ABS, asm_pc);
      run_program();
      for (k = 0; k < 8; k++)
         expect_store(16'h3100 + 2 * k + taken[k], a[k]);
   endtask

   task automatic count_jump_test();
      begin_program(16'h0600);
      emit_imm(`OPC_LDX_IMM, 8'hFE);
      emit(`OPC_INX);
      emit(`OPC_TXA);
      emit_abs(`OPC_STA_ABS, 16'h3200);
      emit(`OPC_INX);
      emit_imm(`OPC_BEQ, 8'h03);
      emit_abs(`OPC_STA_ABS, 16'h32F0);  // Wrong path marker
      emit(`OPC_TXA);
      emit_abs(`OPC_STA_ABS, 16'h3201);
      emit(`OPC_DEX);
      emit_imm(`OPC_BNE, 8'h03);
      emit_abs(`OPC_STA_ABS, 16'h32F1);
      emit(`OPC_TXA);
      emit_abs(`OPC_STA_ABS, 16'h3202);
      emit_imm(`OPC_LDY_IMM, 8'h01);
      emit(`OPC_DEY);
      emit_imm(`OPC_BEQ, 8'h03);
      emit_abs(`OPC_STA_ABS, 16'h32F2);
      emit(`OPC_DEY);
      emit_imm(`OPC_BNE, 8'h03);
      emit_abs(`OPC_STA_ABS, 16'h32F3);
      emit(`OPC_INY);
      emit_imm(`OPC_BEQ, 8'h03);
      emit_abs(`OPC_STA_ABS, 16'h32F4);
      emit_imm(`OPC_LDA_IMM, 8'h5A);
      emit_abs(`OPC_STA_ABS, 16'h3203);
      emit_abs(`OPC_JMP_ABS, 16'h0700);
      emit_abs(`OPC_STA_ABS, 16'h32F5);
      asm_pc = 16'h0700;
      emit_imm(`OPC_LDA_IMM, 8'hA5);
      emit_abs(`OPC_STA_ABS, 16'h3204);
      emit_abs(`OPC_JMP_ABS, asm_pc);
      run_program();
      expect_store(16'h3200, 8'hFF);
      expect_store(16'h3201, 8'h00);
      expect_store(16'h3202, 8'hFF);
      expect_store(16'h3203, 8'h5A);
      expect_store(16'h3204, 8'hA5);
   endtask

   task automatic wait_state_test();
      random_ready = 1'b1;
      run_alu_program();
      random_ready = 1'b0;
   endtask

   initial
   begin
      seed         = 80;
      random_ready = 1'b0;
      rst_req_n    = 1'b1;
      ready        = 1'b1;
      rd_data      = '0;
      reset_vector_test();
      load_store_test();
      logic_arith_test();
      branch_test();
      count_jump_test();
      wait_state_test();
      if (dut0.sva0.fail_count == 0)
      begin
         $display("** PASS **");
         $finish;
      end
      else
         report_failure("bus protocol assertion failed");
   end

endmodule

`default_nettype wire

// ==== tb/cpu_sva.sv ====
// Bus protocol assertions bound into every m6502_core instance.
`timescale 1ns/1ps
`default_nettype none

module cpu_sva (
   input logic               clk,
   input logic               reset_n,
   input cpu_bus_pkg::addr_t addr_o,
   input logic               rd_req_o,
   input logic               wr_en_o,
   input cpu_bus_pkg::data_t wr_data_o,
   input logic               ready_i
);

   int fail_count = 0;

   strobe_excl: assert property (@(posedge clk) !(rd_req_o && wr_en_o))
      else
      begin
         fail_count++;
         $error("rd_req_o and wr_en_o high together");
      end

   // Strobes are registered, so they clear one edge into reset
   strobe_reset: assert property (@(posedge clk) !reset_n |=> !rd_req_o && !wr_en_o)
      else
      begin
         fail_count++;
         $error("bus strobe high during reset");
      end

   hold_on_wait: assert property (@(posedge clk) disable iff (!reset_n)
      (rd_req_o || wr_en_o) && !ready_i |=> $stable(addr_o) && $stable(rd_req_o)
         && $stable(wr_en_o) && $stable(wr_data_o))
      else
      begin
         fail_count++;
         $error("bus cycle changed while ready_i low");
      end

endmodule

bind m6502_core cpu_sva sva0 (
   .clk       (clk),
   .reset_n   (reset_n),
   .addr_o    (addr_o),
   .rd_req_o  (rd_req_o),
   .wr_en_o   (wr_en_o),
   .wr_data_o (wr_data_o),
   .ready_i   (ready_i)
);

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Testbench clock and power-on reset. 20 ns period, reset_n_o low for 2 cycles.
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk_o,
   output logic reset_n_o
);

   initial
   begin
      clk_o     = 1'b0;
      reset_n_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   initial
   begin
      repeat (2) @(posedge clk_o);
      reset_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== hw/m6502_core.sv ====
// Top of the 6502-style core. Connects sequencer, PC, ALU and registers
// to the external memory bus (read request, write enable, ready).
`timescale 1ns/1ps
`default_nettype none

module m6502_core (
   input  logic               clk,
   input  logic               reset_n,
   output cpu_bus_pkg::addr_t addr_o,
   output logic               rd_req_o,
   output logic               wr_en_o,
   output cpu_bus_pkg::data_t wr_data_o,
   input  cpu_bus_pkg::data_t rd_data_i,
   input  logic               ready_i
);

   cpu_bus_pkg::addr_t    pc;
   cpu_bus_pkg::addr_t    pc_target;
   cpu_bus_pkg::data_t    branch_offset;
   cpu_bus_pkg::data_t    operand;
   cpu_bus_pkg::data_t    alu_result;
   cpu_bus_pkg::data_t    alu_a;
   logic                  pc_inc;
   logic                  pc_load;
   logic                  pc_branch;
   logic                  alu_go;
   logic                  flag_n;
   logic                  flag_z;
   logic                  flag_c;
   cpu_isa_pkg::alu_op_t  alu_op;
   cpu_isa_pkg::reg_sel_t reg_rd_sel;
   cpu_isa_pkg::reg_sel_t reg_wr_sel;

   cpu_sequencer seq0 (
      .clk             (clk),
      .reset_n         (reset_n),
      .ready_i         (ready_i),
      .rd_data_i       (rd_data_i),
      .pc_i            (pc),
      .alu_result_i    (alu_result),
      .flag_n_i        (flag_n),
      .flag_z_i        (flag_z),
      .flag_c_i        (flag_c),
      .addr_o          (addr_o),
      .rd_req_o        (rd_req_o),
      .wr_en_o         (wr_en_o),
      .wr_data_o       (wr_data_o),
      .pc_inc_o        (pc_inc),
      .pc_load_o       (pc_load),
      .pc_branch_o     (pc_branch),
      .pc_target_o     (pc_target),
      .branch_offset_o (branch_offset),
      .alu_op_o        (alu_op),
      .alu_go_o        (alu_go),
      .operand_o       (operand),
      .reg_rd_sel_o    (reg_rd_sel),
      .reg_wr_sel_o    (reg_wr_sel)
   );

   cpu_pc_counter pc0 (
      .clk      (clk),
      .reset_n  (reset_n),
      .inc_i    (pc_inc),
      .load_i   (pc_load),
      .branch_i (pc_branch),
      .target_i (pc_target),
      .offset_i (branch_offset),
      .pc_o     (pc)
   );

   cpu_alu alu0 (
      .clk      (clk),
      .reset_n  (reset_n),
      .op_i     (alu_op),
      .go_i     (alu_go),
      .a_i      (alu_a),
      .b_i      (operand),
      .result_o (alu_result),
      .flag_n_o (flag_n),
      .flag_z_o (flag_z),
      .flag_c_o (flag_c)
   );

   cpu_regfile regs0 (
      .clk       (clk),
      .reset_n   (reset_n),
      .rd_sel_i  (reg_rd_sel),
      .wr_sel_i  (reg_wr_sel),
      .wr_data_i (alu_result),
      .rd_data_o (alu_a)
   );

endmodule

`default_nettype wire

// ==== hw/cpu_regfile.sv ====
// A, X and Y registers. One write select and one read select, the read
// feeds ALU input a. A NONE read gives zero.
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
   input  logic                  clk,
   input  logic                  reset_n,
   input  cpu_isa_pkg::reg_sel_t rd_sel_i,
   input  cpu_isa_pkg::reg_sel_t wr_sel_i,
   input  cpu_bus_pkg::data_t    wr_data_i,
   output cpu_bus_pkg::data_t    rd_data_o
);

   cpu_bus_pkg::data_t reg_a_q;
   cpu_bus_pkg::data_t reg_x_q;
   cpu_bus_pkg::data_t reg_y_q;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         reg_a_q <= '0;
         reg_x_q <= '0;
         reg_y_q <= '0;
      end
      else
      begin
         case (wr_sel_i)
            cpu_isa_pkg::A: reg_a_q <= wr_data_i;
            cpu_isa_pkg::X: reg_x_q <= wr_data_i;
            cpu_isa_pkg::Y: reg_y_q <= wr_data_i;
            default: ;
         endcase
      end
   end

   always_comb
   begin
      case (rd_sel_i)
         cpu_isa_pkg::A: rd_data_o = reg_a_q;
         cpu_isa_pkg::X: rd_data_o = reg_x_q;
         cpu_isa_pkg::Y: rd_data_o = reg_y_q;
         default:        rd_data_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/cpu_alu.sv ====
// 8-bit ALU with registered N, Z and C flags. The result is combinational,
// the flags update at the edge where go_i is high.
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
   input  logic                 clk,
   input  logic                 reset_n,
   input  cpu_isa_pkg::alu_op_t op_i,
   input  logic                 go_i,
   input  cpu_bus_pkg::data_t   a_i,
   input  cpu_bus_pkg::data_t   b_i,
   output cpu_bus_pkg::data_t   result_o,
   output logic                 flag_n_o,
   output logic                 flag_z_o,
   output logic                 flag_c_o
);

   localparam int W = $bits(cpu_bus_pkg::data_t);

   logic [W:0] wide;     // Extra bit is carry or borrow
   logic       flag_n_q;
   logic       flag_z_q;
   logic       flag_c_q;

   always_comb
   begin
      case (op_i)
         cpu_isa_pkg::PASS: wide = {1'b0, b_i};
         cpu_isa_pkg::ADC:  wide = {1'b0, a_i} + {1'b0, b_i} + {{W{1'b0}}, flag_c_q};
         cpu_isa_pkg::AND:  wide = {1'b0, a_i & b_i};
         cpu_isa_pkg::ORA:  wide = {1'b0, a_i | b_i};
         cpu_isa_pkg::EOR:  wide = {1'b0, a_i ^ b_i};
         cpu_isa_pkg::CMP:  wide = {1'b0, a_i} - {1'b0, b_i};
         cpu_isa_pkg::INC:  wide = {1'b0, a_i} + 1'b1;
         cpu_isa_pkg::DEC:  wide = {1'b0, a_i} - 1'b1;
         default:           wide = {1'b0, a_i};
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         flag_n_q <= 1'b0;
         flag_z_q <= 1'b0;
         flag_c_q <= 1'b0;
      end
      else if (go_i)
      begin
         case (op_i)
            cpu_isa_pkg::SETC: flag_c_q <= 1'b1;
            cpu_isa_pkg::CLRC: flag_c_q <= 1'b0;
            default:
            begin
               flag_n_q <= wide[W-1];
               flag_z_q <= ~|wide[W-1:0];
               if (op_i == cpu_isa_pkg::ADC)
                  flag_c_q <= wide[W];
               else if (op_i == cpu_isa_pkg::CMP)
                  flag_c_q <= ~wide[W];          // Set when a >= b
            end
         endcase
      end
   end

   assign result_o = wide[W-1:0];
   assign flag_n_o = flag_n_q;
   assign flag_z_o = flag_z_q;
   assign flag_c_o = flag_c_q;

endmodule

`default_nettype wire

// ==== hw/cpu_pc_counter.sv ====
// Program counter. Steps by one, loads a jump target or adds a signed
// branch offset. A control seen in one cycle shows in pc_o after the edge.
`timescale 1ns/1ps
`default_nettype none

module cpu_pc_counter (
   input  logic               clk,
   input  logic               reset_n,
   input  logic               inc_i,
   input  logic               load_i,
   input  logic               branch_i,
   input  cpu_bus_pkg::addr_t target_i,
   input  cpu_bus_pkg::data_t offset_i,
   output cpu_bus_pkg::addr_t pc_o
);

   localparam int AW = $bits(cpu_bus_pkg::addr_t);
   localparam int DW = $bits(cpu_bus_pkg::data_t);

   cpu_bus_pkg::addr_t pc_q;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         pc_q <= '0;
      else if (load_i)
         pc_q <= target_i;
      else if (branch_i)
         pc_q <= pc_q + {{(AW-DW){offset_i[DW-1]}}, offset_i};   // Sign extended
      else if (inc_i)
         pc_q <= pc_q + 1'b1;
   end

   assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== hw/cpu_sequencer.sv ====
// Instruction sequencer. Reads the reset vector, fetches and decodes each
// opcode, runs the operand and memory cycles, then commits in one EXEC cycle.
// Bus strobes, address and write data are all driven from registers.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module cpu_sequencer (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  ready_i,
   input  cpu_bus_pkg::data_t    rd_data_i,
   input  cpu_bus_pkg::addr_t    pc_i,
   input  cpu_bus_pkg::data_t    alu_result_i,
   input  logic                  flag_n_i,
   input  logic                  flag_z_i,
   input  logic                  flag_c_i,
   output cpu_bus_pkg::addr_t    addr_o,
   output logic                  rd_req_o,
   output logic                  wr_en_o,
   output cpu_bus_pkg::data_t    wr_data_o,
   output logic                  pc_inc_o,
   output logic                  pc_load_o,
   output logic                  pc_branch_o,
   output cpu_bus_pkg::addr_t    pc_target_o,
   output cpu_bus_pkg::data_t    branch_offset_o,
   output cpu_isa_pkg::alu_op_t  alu_op_o,
   output logic                  alu_go_o,
   output cpu_bus_pkg::data_t    operand_o,
   output cpu_isa_pkg::reg_sel_t reg_rd_sel_o,
   output cpu_isa_pkg::reg_sel_t reg_wr_sel_o
);

   cpu_bus_pkg::seq_state_t state_q;
   logic                    cap_q;        // Read completed, byte arrives now
   logic                    rd_req_q;
   logic                    wr_en_q;
   cpu_bus_pkg::addr_t      addr_q;
   cpu_bus_pkg::data_t      wr_data_q;
   cpu_bus_pkg::data_t      opcode_q;
   cpu_bus_pkg::data_t      opr_lo_q;
   cpu_bus_pkg::data_t      opr_hi_q;
   cpu_bus_pkg::data_t      mem_data_q;
   cpu_isa_pkg::opc_class_t cls;
   cpu_isa_pkg::opc_class_t next_cls;
   cpu_isa_pkg::reg_sel_t   wr_sel;
   logic                    short_op;
   logic                    alu_writes;
   logic                    branch_flag;

   function automatic cpu_isa_pkg::opc_class_t decode_class(
      input cpu_bus_pkg::data_t opc
   );
      case (opc)
         `OPC_LDA_IMM, `OPC_LDX_IMM, `OPC_LDY_IMM, `OPC_ADC_IMM,
         `OPC_AND_IMM, `OPC_ORA_IMM, `OPC_EOR_IMM, `OPC_CMP_IMM:
            return cpu_isa_pkg::CLS_IMM;
         `OPC_BEQ, `OPC_BNE, `OPC_BCC, `OPC_BCS:
            return cpu_isa_pkg::CLS_BRANCH;
         `OPC_JMP_ABS: return cpu_isa_pkg::CLS_JMP;
         `OPC_LDA_ABS: return cpu_isa_pkg::CLS_LOAD_ABS;
         `OPC_STA_ABS: return cpu_isa_pkg::CLS_STORE_ABS;
         default:      return cpu_isa_pkg::CLS_IMPLIED;   // Unknown opcodes run as NOP
      endcase
   endfunction

   assign cls      = decode_class(opcode_q);
   assign next_cls = decode_class(rd_data_i);     // Opcode byte during fetch capture
   assign short_op = (cls == cpu_isa_pkg::CLS_IMM) || (cls == cpu_isa_pkg::CLS_BRANCH);

   always_comb
   begin
      alu_op_o     = cpu_isa_pkg::PASS;
      reg_rd_sel_o = cpu_isa_pkg::NONE;
      wr_sel       = cpu_isa_pkg::NONE;
      case (opcode_q)
         `OPC_ADC_IMM:        alu_op_o = cpu_isa_pkg::ADC;
         `OPC_AND_IMM:        alu_op_o = cpu_isa_pkg::AND;
         `OPC_ORA_IMM, `OPC_STA_ABS, `OPC_TAX, `OPC_TXA:
            alu_op_o = cpu_isa_pkg::ORA;              // With operand 0 this copies a
         `OPC_EOR_IMM:        alu_op_o = cpu_isa_pkg::EOR;
         `OPC_CMP_IMM:        alu_op_o = cpu_isa_pkg::CMP;
         `OPC_INX, `OPC_INY:  alu_op_o = cpu_isa_pkg::INC;
         `OPC_DEX, `OPC_DEY:  alu_op_o = cpu_isa_pkg::DEC;
         `OPC_SEC:            alu_op_o = cpu_isa_pkg::SETC;
         `OPC_CLC:            alu_op_o = cpu_isa_pkg::CLRC;
         default: ;
      endcase
      case (opcode_q)
         `OPC_ADC_IMM, `OPC_AND_IMM, `OPC_ORA_IMM, `OPC_EOR_IMM, `OPC_CMP_IMM,
         `OPC_STA_ABS, `OPC_TAX:
            reg_rd_sel_o = cpu_isa_pkg::A;
         `OPC_INX, `OPC_DEX, `OPC_TXA: reg_rd_sel_o = cpu_isa_pkg::X;
         `OPC_INY, `OPC_DEY:           reg_rd_sel_o = cpu_isa_pkg::Y;
         default: ;
      endcase
      case (opcode_q)
         `OPC_LDA_IMM, `OPC_LDA_ABS, `OPC_ADC_IMM, `OPC_AND_IMM, `OPC_ORA_IMM,
         `OPC_EOR_IMM, `OPC_TXA:
            wr_sel = cpu_isa_pkg::A;
         `OPC_LDX_IMM, `OPC_INX, `OPC_DEX, `OPC_TAX: wr_sel = cpu_isa_pkg::X;
         `OPC_LDY_IMM, `OPC_INY, `OPC_DEY:           wr_sel = cpu_isa_pkg::Y;
         default: ;
      endcase
   end

   // Flags change for every register write, for CMP and for SEC/CLC
   assign alu_writes = (wr_sel != cpu_isa_pkg::NONE) || (alu_op_o == cpu_isa_pkg::CMP)
                    || (alu_op_o == cpu_isa_pkg::SETC) || (alu_op_o == cpu_isa_pkg::CLRC);

   // Branch condition follows opcode bits 7:5, as on the 6502
   always_comb
   begin
      case (opcode_q[7:6])
         2'b00:   branch_flag = flag_n_i;
         2'b10:   branch_flag = flag_c_i;
         2'b11:   branch_flag = flag_z_i;
         default: branch_flag = 1'b0;      // No V flag
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state_q  <= cpu_bus_pkg::VEC_LO;
         cap_q    <= 1'b0;
         rd_req_q <= 1'b0;
         wr_en_q  <= 1'b0;
      end
      else if (state_q == cpu_bus_pkg::EXEC)
      begin
         state_q <= cpu_bus_pkg::FETCH;
      end
      else if (rd_req_q || wr_en_q)
      begin
         if (ready_i)                      // Bus cycle completes
         begin
            rd_req_q <= 1'b0;
            wr_en_q  <= 1'b0;
            cap_q    <= rd_req_q;
            if (wr_en_q)
               state_q <= cpu_bus_pkg::EXEC;
         end
      end
      else if (cap_q)
      begin
         cap_q <= 1'b0;
         case (state_q)
            cpu_bus_pkg::VEC_LO:
            begin
               opr_lo_q <= rd_data_i;
               addr_q   <= `RST_VECTOR + 1'b1;
               rd_req_q <= 1'b1;
               state_q  <= cpu_bus_pkg::VEC_HI;
            end
            cpu_bus_pkg::VEC_HI:
            begin
               addr_q   <= {rd_data_i, opr_lo_q};   // PC loads the same vector
               rd_req_q <= 1'b1;
               state_q  <= cpu_bus_pkg::FETCH;
            end
            cpu_bus_pkg::FETCH:
            begin
               opcode_q <= rd_data_i;
               addr_q   <= pc_i + 1'b1;
               rd_req_q <= (next_cls != cpu_isa_pkg::CLS_IMPLIED);
               state_q  <= (next_cls == cpu_isa_pkg::CLS_IMPLIED) ? cpu_bus_pkg::EXEC
                                                                  : cpu_bus_pkg::OPER_LO;
            end
            cpu_bus_pkg::OPER_LO:
            begin
               opr_lo_q <= rd_data_i;
               addr_q   <= pc_i + 1'b1;
               rd_req_q <= !short_op;
               state_q  <= short_op ? cpu_bus_pkg::EXEC : cpu_bus_pkg::OPER_HI;
            end
            cpu_bus_pkg::OPER_HI:
            begin
               opr_hi_q  <= rd_data_i;
               addr_q    <= {rd_data_i, opr_lo_q};
               wr_data_q <= alu_result_i;          // A for STA
               rd_req_q  <= (cls == cpu_isa_pkg::CLS_LOAD_ABS);
               wr_en_q   <= (cls == cpu_isa_pkg::CLS_STORE_ABS);
               state_q   <= (cls == cpu_isa_pkg::CLS_JMP) ? cpu_bus_pkg::EXEC
                                                          : cpu_bus_pkg::MEM;
            end
            cpu_bus_pkg::MEM:
            begin
               mem_data_q <= rd_data_i;
               state_q    <= cpu_bus_pkg::EXEC;
            end
            default: ;
         endcase
      end
      else
      begin
         // Only after reset (vector) or after EXEC (opcode fetch)
         rd_req_q <= 1'b1;
         addr_q   <= (state_q == cpu_bus_pkg::VEC_LO) ? `RST_VECTOR : pc_i;
      end
   end

   assign addr_o    = addr_q;
   assign rd_req_o  = rd_req_q;
   assign wr_en_o   = wr_en_q;
   assign wr_data_o = wr_data_q;

   assign pc_inc_o    = cap_q && ((state_q == cpu_bus_pkg::FETCH)
                     || (state_q == cpu_bus_pkg::OPER_LO) || (state_q == cpu_bus_pkg::OPER_HI));
   assign pc_load_o   = (cap_q && (state_q == cpu_bus_pkg::VEC_HI))
                     || ((state_q == cpu_bus_pkg::EXEC) && (cls == cpu_isa_pkg::CLS_JMP));
   assign pc_branch_o = (state_q == cpu_bus_pkg::EXEC) && (cls == cpu_isa_pkg::CLS_BRANCH)
                     && (opcode_q[5] == branch_flag);
   assign pc_target_o = (state_q == cpu_bus_pkg::VEC_HI) ? {rd_data_i, opr_lo_q}
                                                         : {opr_hi_q, opr_lo_q};
   assign branch_offset_o = opr_lo_q;

   assign alu_go_o     = (state_q == cpu_bus_pkg::EXEC) && alu_writes;
   assign reg_wr_sel_o = (state_q == cpu_bus_pkg::EXEC) ? wr_sel : cpu_isa_pkg::NONE;
   assign operand_o    = (cls == cpu_isa_pkg::CLS_LOAD_ABS) ? mem_data_q
                       : (cls == cpu_isa_pkg::CLS_IMM)      ? opr_lo_q
                       : '0;

endmodule

`default_nettype wire

// ==== hw/cpu_bus_pkg.sv ====
// Bus and sequencer types for the 6502-style core.
`default_nettype none
`include "cpu_consts.svh"

package cpu_bus_pkg;

   typedef logic [`ADDR_W-1:0] addr_t;
   typedef logic [`DATA_W-1:0] data_t;

   typedef enum logic [2:0] {
      VEC_LO,    // Reset vector low byte
      VEC_HI,
      FETCH,
      OPER_LO,
      OPER_HI,
      MEM,       // Data read or write
      EXEC
   } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/cpu_isa_pkg.sv ====
// Instruction set types: opcode class, ALU operation and register select.
// Shared by the sequencer, the ALU and the register file.
`default_nettype none

package cpu_isa_pkg;

   // Addressing length of an opcode
   typedef enum logic [2:0] {
      CLS_IMPLIED,
      CLS_IMM,
      CLS_BRANCH,
      CLS_JMP,
      CLS_LOAD_ABS,
      CLS_STORE_ABS
   } opc_class_t;

   typedef enum logic [3:0] {
      PASS, ADC, AND, ORA, EOR, CMP,
      INC, DEC,
      SETC, CLRC
   } alu_op_t;

   typedef enum logic [1:0] {
      NONE, A, X, Y
   } reg_sel_t;

endpackage

`default_nettype wire

// ==== hw/cpu_consts.svh ====
// Widths, reset vector and opcode bytes of the 6502-style core.
// Included by the bus package, the sequencer and the testbench program assembly.
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define ADDR_W       16
`define DATA_W       8
`define RST_VECTOR   16'hFFFC   // Low byte of the start address

`define OPC_LDA_IMM  8'hA9
`define OPC_LDX_IMM  8'hA2
`define OPC_LDY_IMM  8'hA0
`define OPC_LDA_ABS  8'hAD
`define OPC_STA_ABS  8'h8D
`define OPC_ADC_IMM  8'h69
`define OPC_AND_IMM  8'h29
`define OPC_ORA_IMM  8'h09
`define OPC_EOR_IMM  8'h49
`define OPC_CMP_IMM  8'hC9
`define OPC_INX      8'hE8
`define OPC_DEX      8'hCA
`define OPC_INY      8'hC8
`define OPC_DEY      8'h88
`define OPC_TAX      8'hAA
`define OPC_TXA      8'h8A
`define OPC_CLC      8'h18
`define OPC_SEC      8'h38
`define OPC_JMP_ABS  8'h4C
`define OPC_BEQ      8'hF0
`define OPC_BNE      8'hD0
`define OPC_BCC      8'h90
`define OPC_BCS      8'hB0
`define OPC_NOP      8'hEA

`endif
